// File: Bender.yml
package:
  name: plot_eval

sources:
  - files:
      - rtl/plot_pkg.sv
      - rtl/plot_ifs.sv
      - rtl/plot_regs.sv
      - rtl/fixed_point_alu.sv
      - rtl/stack_machine.sv
      - rtl/plot_eval_top.sv
  - target: simulation
    files:
      - sim/plot_checker.sv
      - sim/tb_plot_eval.sv

// File: rtl/fixed_point_alu.sv
`timescale 1ns/10ps

module fixed_point_alu (
    input logic clk,
    input logic rst,
    alu_if.unit alu
);
    import plot_pkg::*;

    logic signed [31:0] product;
    logic [15:0] mag_a;
    logic [15:0] mag_b;
    logic        div_busy;
    logic [3:0]  div_cnt;
    logic        div_neg;
    logic        den_zero;
    logic [15:0] den;
    logic [31:0] num;
    logic [16:0] rem;
    logic [15:0] quo;
    logic [17:0] step_hi;
    logic [17:0] step_lo;
    logic [15:0] quo_next;

    // one restoring step, returns {quotient bit, new remainder}
    function automatic logic [17:0] div_step(input logic [16:0] r, input logic bit_in,
                                             input logic [15:0] d);
        logic [16:0] t;
        t = {r[15:0], bit_in};
        if (t >= {1'b0, d}) begin
            return {1'b1, t - {1'b0, d}};
        end
        return {1'b0, t};
    endfunction

    assign product = alu.a * alu.b;
    assign mag_a   = alu.a[15] ? -alu.a : alu.a;
    assign mag_b   = alu.b[15] ? -alu.b : alu.b;

    // two dividend bits per cycle, 32-bit dividend in 16 cycles
    always_comb begin
        step_hi = div_step(rem, num[31], den);
        step_lo = div_step(step_hi[16:0], num[30], den);
    end
    assign quo_next = {quo[13:0], step_hi[17], step_lo[17]};

    always_ff @(posedge clk) begin
        if (rst) begin
            div_busy <= 1'b0;
            div_cnt  <= '0;
            alu.done <= 1'b0;
        end else begin
            alu.done <= 1'b0;
            if (alu.start) begin
                div_busy <= alu.op == OP_DIV;
                div_cnt  <= '0;
                alu.done <= alu.op != OP_DIV;
            end else if (div_busy) begin
                div_cnt <= div_cnt + 4'd1;
                if (div_cnt == 4'd15) begin
                    div_busy <= 1'b0;
                    alu.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu.start) begin
            case (alu.op)
                OP_ADD: alu.result <= alu.a + alu.b;
                OP_SUB: alu.result <= alu.a - alu.b;
                OP_MUL: alu.result <= product[frac_bits + 15:frac_bits];
                OP_DIV: begin
                    num      <= {8'd0, mag_a, {frac_bits{1'b0}}};
                    den      <= mag_b;
                    rem      <= '0;
                    quo      <= '0;
                    div_neg  <= alu.a[15] ^ alu.b[15];
                    den_zero <= alu.b == '0;
                end
                default: ;
            endcase
        end else if (div_busy) begin
            rem <= step_lo[16:0];
            num <= {num[29:0], 2'b00};
            quo <= quo_next;
            if (div_cnt == 4'd15) begin
                alu.result <= den_zero ? '0 : (div_neg ? -quo_next : quo_next);
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        alu.start |-> !div_busy)
        else $error("ALU start while a divide is in progress");

endmodule

// File: rtl/plot_eval_top.sv
`timescale 1ns/10ps

module plot_eval_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    token_if tok_bus ();
    alu_if   alu_bus ();

    logic       run_start;
    logic [9:0] x_pixel;
    logic       busy;
    logic       done;
    logic [7:0] y_row;
    logic       div_zero;
    logic       stack_err;

    plot_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tok       (tok_bus.store),
        .run_start (run_start),
        .x_pixel   (x_pixel),
        .busy      (busy),
        .done      (done),
        .y_row     (y_row),
        .div_zero  (div_zero),
        .stack_err (stack_err)
    );

    stack_machine u_sm (
        .clk       (clk),
        .rst       (rst),
        .tok       (tok_bus.reader),
        .alu       (alu_bus.master),
        .run_start (run_start),
        .x_pixel   (x_pixel),
        .busy      (busy),
        .done      (done),
        .y_row     (y_row),
        .div_zero  (div_zero),
        .stack_err (stack_err)
    );

    fixed_point_alu u_alu (
        .clk (clk),
        .rst (rst),
        .alu (alu_bus.unit)
    );

endmodule

// File: rtl/plot_ifs.sv
`timescale 1ns/10ps

// token reads from the expression memory
interface token_if;
    import plot_pkg::*;

    tok_idx_t index;
    logic     get;
    tok_len_t length;
    token_t   data;
    logic     ready;

    modport reader (
        output index,
        output get,
        input  length,
        input  data,
        input  ready
    );

    modport store (
        input  index,
        input  get,
        output length,
        output data,
        output ready
    );
endinterface

// start/done handshake to the fixed-point ALU
interface alu_if;
    import plot_pkg::*;

    logic    start;
    alu_op_t op;
    num_t    a;
    num_t    b;
    num_t    result;
    logic    done;

    modport master (output start, output op, output a, output b, input result, input done);
    modport unit (input start, input op, input a, input b, output result, output done);
endinterface

// File: rtl/plot_pkg.sv
package plot_pkg;

    // signed Q8.8
    localparam int frac_bits = 8;
    typedef logic signed [15:0] num_t;

    // bit 16 marks an operator, code in bits 2..0
    typedef logic [16:0] token_t;
    localparam int token_depth = 64;
    typedef logic [5:0] tok_idx_t;
    typedef logic [6:0] tok_len_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_DIV = 3'd3
    } alu_op_t;

    // push transformed x
    localparam logic [2:0] tok_var = 3'd6;

    localparam int stack_depth = 16;

    localparam int hor_center = 320;
    localparam int ver_center = 240;
    localparam int plot_scale = 20;

    typedef enum logic [3:0] {
        S_IDLE, S_XSUB, S_XDIV, S_FETCH,
        S_WAIT_TOK, S_DECODE, S_PUSH, S_OP,
        S_YMUL, S_YSUB, S_ALU_WAIT, S_DONE
    } sm_state_t;

    localparam logic [11:0] reg_ctrl     = 12'h000;
    localparam logic [11:0] reg_status   = 12'h004;
    localparam logic [11:0] reg_x_in     = 12'h008;
    localparam logic [11:0] reg_y_out    = 12'h00C;
    localparam logic [11:0] reg_len      = 12'h010;
    localparam logic [11:0] reg_tok_base = 12'h100;

endpackage

// File: rtl/plot_regs.sv
`timescale 1ns/10ps

module plot_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    token_if.store      tok,
    output logic        run_start,
    output logic [9:0]  x_pixel,
    input  logic        busy,
    input  logic        done,
    input  logic [7:0]  y_row,
    input  logic        div_zero,
    input  logic        stack_err
);
    import plot_pkg::*;

    token_t   mem [token_depth];
    tok_len_t len;
    tok_idx_t tok_addr;
    logic     st_done;
    logic     st_dz;
    logic     st_se;
    logic     access;
    logic     is_ctrl;
    logic     is_status;
    logic     is_x;
    logic     is_y;
    logic     is_len;
    logic     is_tok;
    logic     mapped;
    logic     locked;
    logic     wr_ok;

    assign access    = psel && penable;
    assign is_ctrl   = paddr == reg_ctrl;
    assign is_status = paddr == reg_status;
    assign is_x      = paddr == reg_x_in;
    assign is_y      = paddr == reg_y_out;
    assign is_len    = paddr == reg_len;
    assign is_tok    = paddr[11:8] == reg_tok_base[11:8] && paddr[1:0] == 2'b00;
    assign mapped    = is_ctrl || is_status || is_x || is_y || is_len || is_tok;
    assign tok_addr  = paddr[7:2];

    // expression and start are frozen while a run is going
    assign locked  = busy && pwrite && (is_ctrl || is_len || is_tok);
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || locked);
    assign wr_ok   = access && pwrite && mapped && !locked;

    assign tok.length = len;

    always_comb begin
        prdata = '0;
        if (is_status) begin
            prdata = {28'd0, st_se, st_dz, st_done, busy};
        end else if (is_x) begin
            prdata = {22'd0, x_pixel};
        end else if (is_y) begin
            prdata = {{24{y_row[7]}}, y_row};
        end else if (is_len) begin
            prdata = {25'd0, len};
        end else if (is_tok) begin
            prdata = {15'd0, mem[tok_addr]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_start <= 1'b0;
            x_pixel   <= '0;
            len       <= '0;
            st_done   <= 1'b0;
            st_dz     <= 1'b0;
            st_se     <= 1'b0;
            tok.ready <= 1'b0;
        end else begin
            run_start <= wr_ok && is_ctrl && pwdata[0];
            tok.ready <= tok.get;
            if (wr_ok && is_x) begin
                x_pixel <= pwdata[9:0];
            end
            if (wr_ok && is_len) begin
                len <= pwdata[6:0];
            end
            if (run_start) begin
                st_done <= 1'b0;
                st_dz   <= 1'b0;
                st_se   <= 1'b0;
            end else begin
                if (done) st_done <= 1'b1;
                if (div_zero) st_dz <= 1'b1;
                if (stack_err) st_se <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && is_tok) begin
            mem[tok_addr] <= pwdata[16:0];
        end
        if (tok.get) begin
            tok.data <= mem[tok.index];
        end
    end

    a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> $stable(paddr))
        else $error("paddr changed between setup and access phase");

endmodule

// File: rtl/stack_machine.sv
`timescale 1ns/10ps

module stack_machine (
    input  logic       clk,
    input  logic       rst,
    token_if.reader    tok,
    alu_if.master      alu,
    input  logic       run_start,
    input  logic [9:0] x_pixel,
    output logic       busy,
    output logic       done,
    output logic [7:0] y_row,
    output logic       div_zero,
    output logic       stack_err
);
    import plot_pkg::*;

    sm_state_t  state;
    sm_state_t  phase;
    num_t       stack [stack_depth];
    logic [4:0] sp;
    logic [3:0] top_idx;
    logic [3:0] nxt_idx;
    tok_len_t   pos;
    token_t     tok_cur;
    num_t       x_val;
    num_t       push_val;
    logic       is_var;
    logic       is_op;

    assign top_idx  = sp[3:0] - 4'd1;
    assign nxt_idx  = sp[3:0] - 4'd2;
    assign is_var   = tok_cur[16] && tok_cur[2:0] == tok_var;
    assign is_op    = tok_cur[16] && !tok_cur[2];
    assign push_val = is_var ? x_val : tok_cur[15:0];

    assign busy      = state != S_IDLE;
    assign done      = state == S_DONE;
    assign tok.index = pos[5:0];
    assign tok.get   = state == S_FETCH && pos < tok.length;
    assign alu.start = state inside {S_XSUB, S_XDIV, S_OP, S_YMUL, S_YSUB};

    always_comb begin
        alu.op = OP_SUB;
        alu.a  = '0;
        alu.b  = '0;
        case (state)
            S_XSUB: begin
                // offset in whole pixels, the divide's shift makes it Q8.8
                alu.a = num_t'({6'd0, x_pixel});
                alu.b = num_t'(hor_center);
            end
            S_XDIV: begin
                alu.op = OP_DIV;
                alu.a  = alu.result;
                alu.b  = num_t'(plot_scale);
            end
            S_OP: begin
                alu.op = alu_op_t'({1'b0, tok_cur[1:0]});
                alu.a  = stack[top_idx];
                alu.b  = stack[nxt_idx];
            end
            S_YMUL: begin
                alu.op = OP_MUL;
                alu.a  = stack[0];
                alu.b  = num_t'(plot_scale << frac_bits);
            end
            S_YSUB: begin
                // 240 wraps in Q8.8, low byte of the row still comes out right
                alu.a = num_t'(ver_center << frac_bits);
                alu.b = alu.result;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            phase     <= S_IDLE;
            sp        <= '0;
            pos       <= '0;
            y_row     <= '0;
            div_zero  <= 1'b0;
            stack_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (run_start) begin
                        sp        <= '0;
                        pos       <= '0;
                        div_zero  <= 1'b0;
                        stack_err <= 1'b0;
                        state     <= S_XSUB;
                    end
                end
                S_XSUB, S_XDIV, S_OP, S_YMUL, S_YSUB: begin
                    if (state == S_OP && alu.op == OP_DIV && alu.b == '0) begin
                        div_zero <= 1'b1;
                    end
                    phase <= state;
                    state <= S_ALU_WAIT;
                end
                S_FETCH: begin
                    if (tok.get) begin
                        state <= S_WAIT_TOK;
                    end else if (sp != 5'd1) begin
                        stack_err <= 1'b1;
                        state     <= S_DONE;
                    end else begin
                        state <= S_YMUL;
                    end
                end
                S_WAIT_TOK: begin
                    if (tok.ready) begin
                        pos   <= pos + 7'd1;
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (!tok_cur[16] || is_var) begin
                        state <= S_PUSH;
                    end else if (!is_op || sp < 5'd2) begin
                        // unknown codes abort like a malformed expression
                        stack_err <= 1'b1;
                        state     <= S_DONE;
                    end else begin
                        state <= S_OP;
                    end
                end
                S_PUSH: begin
                    if (sp == 5'(stack_depth)) begin
                        stack_err <= 1'b1;
                        state     <= S_DONE;
                    end else begin
                        sp    <= sp + 5'd1;
                        state <= S_FETCH;
                    end
                end
                S_ALU_WAIT: begin
                    if (alu.done) begin
                        case (phase)
                            S_XSUB: state <= S_XDIV;
                            S_XDIV: state <= S_FETCH;
                            S_OP: begin
                                sp    <= sp - 5'd1;
                                state <= S_FETCH;
                            end
                            S_YMUL: state <= S_YSUB;
                            default: begin
                                y_row <= alu.result[15:frac_bits];
                                state <= S_DONE;
                            end
                        endcase
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT_TOK && tok.ready) begin
            tok_cur <= tok.data;
        end
        if (state == S_ALU_WAIT && alu.done && phase == S_XDIV) begin
            x_val <= alu.result;
        end
        if (state == S_PUSH && sp < 5'(stack_depth)) begin
            stack[sp[3:0]] <= push_val;
        end else if (state == S_ALU_WAIT && alu.done && phase == S_OP) begin
            stack[nxt_idx] <= alu.result;
        end
    end

    a_sp_bound: assert property (@(posedge clk) disable iff (rst)
        sp <= 5'(stack_depth))
        else $error("stack pointer beyond stack depth");

endmodule

// File: sim/plot_checker.sv
`timescale 1ns/10ps

module plot_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic [1:0]  row_class,
    output int          errors,
    output int          tests
);
    import plot_pkg::*;

    logic [16:0] mem [64];
    logic [6:0]  len;
    logic [9:0]  x_pix;
    logic [31:0] exp_y;
    logic        exp_dz;
    logic        exp_se;
    logic        running;
    logic        started;
    logic        test_bad;

    task automatic report(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors = errors + 1;
        test_bad = 1'b1;
    endtask

    // Q8.8 quotient on magnitudes truncated toward zero
    function automatic logic [15:0] q_div(input logic [15:0] a, input logic [15:0] b);
        int ma;
        int mb;
        int q;
        if (b == 16'd0) begin
            return 16'd0;
        end
        ma = a[15] ? 65536 - a : a;
        mb = b[15] ? 65536 - b : b;
        q = (ma * 256) / mb;
        return (a[15] ^ b[15]) ? 16'(-q) : 16'(q);
    endfunction

    function automatic logic [15:0] q_mul(input logic [15:0] a, input logic [15:0] b);
        int p;
        p = $signed(a) * $signed(b);
        return p[23:8];
    endfunction

    task automatic evaluate();
        logic [15:0] st [16];
        logic [15:0] xq;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [16:0] t;
        int          sp;
        int          i;
        xq = q_div(16'(int'(x_pix) - 320), 16'd20);
        sp = 0;
        exp_dz = 1'b0;
        exp_se = 1'b0;
        for (i = 0; i < len && !exp_se; i++) begin
            t = mem[i % 64];
            if (!t[16] || t[2:0] == 3'd6) begin
                if (sp == 16) begin
                    exp_se = 1'b1;
                end else begin
                    st[sp] = t[16] ? xq : t[15:0];
                    sp = sp + 1;
                end
            end else if (t[2] || sp < 2) begin
                exp_se = 1'b1;
            end else begin
                // top op next
                a = st[sp - 1];
                b = st[sp - 2];
                case (t[1:0])
                    2'd0: r = a + b;
                    2'd1: r = a - b;
                    2'd2: r = q_mul(a, b);
                    default: begin
                        r = q_div(a, b);
                        if (b == 16'd0) exp_dz = 1'b1;
                    end
                endcase
                st[sp - 2] = r;
                sp = sp - 1;
            end
        end
        if (!exp_se && sp != 1) begin
            exp_se = 1'b1;
        end
        if (!exp_se) begin
            r = 16'(240 * 256 - $signed(st[0]) * 20);
            exp_y = {{24{r[15]}}, r[15:8]};
        end
    endtask

    always @(posedge clk) begin : snoop
        logic is_tok;
        logic mapped;
        logic exp_err;
        logic [3:0] exp_st;
        if (rst) begin
            len      = '0;
            x_pix    = '0;
            exp_y    = '0;
            exp_dz   = 1'b0;
            exp_se   = 1'b0;
            running  = 1'b0;
            started  = 1'b0;
            test_bad = 1'b0;
            errors   = 0;
            tests    = 0;
        end else if (psel && penable) begin
            is_tok = paddr[11:8] == 4'h1 && paddr[1:0] == 2'b00;
            mapped = is_tok || paddr inside {reg_ctrl, reg_status, reg_x_in, reg_y_out, reg_len};
            exp_err = !mapped || (pwrite && running && (is_tok || paddr inside {reg_ctrl, reg_len}));
            if (pready !== 1'b1) begin
                report($sformatf("pready %0b at address %h, expected 1", pready, paddr));
            end
            if (pslverr !== exp_err) begin
                report($sformatf("pslverr %0b at address %h, expected %0b",
                                 pslverr, paddr, exp_err));
            end
            if (pwrite && !exp_err) begin
                if (is_tok) begin
                    mem[paddr[7:2]] = pwdata[16:0];
                end else if (paddr == reg_len) begin
                    len = pwdata[6:0];
                end else if (paddr == reg_x_in) begin
                    x_pix = pwdata[9:0];
                end else if (paddr == reg_ctrl && pwdata[0]) begin
                    evaluate();
                    running = 1'b1;
                    started = 1'b1;
                end
            end else if (!pwrite && mapped) begin
                case (paddr)
                    reg_ctrl: begin
                        if (prdata !== 32'd0) report($sformatf("ctrl read %h", prdata));
                    end
                    reg_status: begin
                        exp_st = {exp_se, exp_dz, started, 1'b0};
                        if (running && !prdata[1]) begin
                            if (prdata[0] !== 1'b1) begin
                                report("status shows busy clear while an evaluation runs");
                            end
                        end else begin
                            if (prdata[3:0] !== exp_st) begin
                                report($sformatf("status %h, expected %h", prdata[3:0], exp_st));
                            end
                            // outcome class from the stimulus table
                            if (running && row_class == 2'd0 && prdata[3:2] != 2'b00) begin
                                report("flags set on a row expected to pass cleanly");
                            end
                            if (running && row_class == 2'd1 && !prdata[2]) begin
                                report("div_zero missing on a divide by zero row");
                            end
                            if (running && row_class == 2'd2 && !prdata[3]) begin
                                report("stack_err missing on a malformed row");
                            end
                            running = 1'b0;
                        end
                    end
                    reg_x_in: begin
                        if (prdata !== {22'd0, x_pix}) report($sformatf("x_in read %h", prdata));
                    end
                    reg_len: begin
                        if (prdata !== {25'd0, len}) report($sformatf("len read %h", prdata));
                    end
                    reg_y_out: begin
                        if (prdata !== exp_y) begin
                            report($sformatf("y_out %0d, expected %0d",
                                             $signed(prdata), $signed(exp_y)));
                        end
                        tests = tests + 1;
                        $display("test %0d: y_out %0d, %s", tests, $signed(prdata),
                                 test_bad ? "mismatch" : "ok");
                        test_bad = 1'b0;
                    end
                    default: begin
                        if (prdata !== {15'd0, mem[paddr[7:2]]}) begin
                            report($sformatf("token %0d read %h", paddr[7:2], prdata));
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: sim/tb_plot_eval.sv
`timescale 1ns/10ps

module tb_plot_eval;
    import plot_pkg::*;

    localparam logic [16:0] t_add = 17'h1_0000;
    localparam logic [16:0] t_sub = 17'h1_0001;
    localparam logic [16:0] t_mul = 17'h1_0002;
    localparam logic [16:0] t_div = 17'h1_0003;
    localparam logic [16:0] t_var = 17'h1_0006;
    localparam logic [1:0]  cls_ok  = 2'd0;
    localparam logic [1:0]  cls_dz  = 2'd1;
    localparam logic [1:0]  cls_se  = 2'd2;
    localparam logic [1:0]  cls_any = 2'd3;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [1:0]  row_class;
    int          errors;
    int          tests;
    int          cycles;
    int          limit;
    integer      seed;

    // stimulus table with the tokens of all rows in one flat queue
    logic [16:0] tab_tok [$];
    int          tab_first [$];
    int          tab_len [$];
    int          tab_x [$];
    logic [1:0]  tab_cls [$];
    bit          tab_probe [$];

    plot_eval_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    plot_checker u_check (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .row_class (row_class),
        .errors    (errors),
        .tests     (tests)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the evaluation never finished within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [16:0] cst(input logic [15:0] v);
        return {1'b0, v};
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic open_row(input int x, input logic [1:0] cls, input bit probe);
        tab_first.push_back(tab_tok.size());
        tab_x.push_back(x);
        tab_cls.push_back(cls);
        tab_probe.push_back(probe);
    endtask

    task automatic close_row();
        tab_len.push_back(tab_tok.size() - tab_first[tab_first.size() - 1]);
    endtask

    task automatic add_row(input int x, input logic [1:0] cls, input bit probe, input int n,
                           input logic [16:0] t0, input logic [16:0] t1,
                           input logic [16:0] t2, input logic [16:0] t3,
                           input logic [16:0] t4);
        logic [16:0] slot [5];
        int          i;
        slot = '{t0, t1, t2, t3, t4};
        open_row(x, cls, probe);
        for (i = 0; i < n; i++) begin
            tab_tok.push_back(slot[i]);
        end
        close_row();
    endtask

    task automatic push_operand();
        if ({$random(seed)} % 3 == 0) begin
            tab_tok.push_back(t_var);
        end else begin
            tab_tok.push_back(cst(16'($random(seed))));
        end
    endtask

    task automatic build_table();
        int n;
        int k;
        int j;
        add_row(0, cls_ok, 0, 1, cst(16'h0280), 0, 0, 0, 0);
        add_row(320, cls_ok, 0, 1, cst(16'hFF00), 0, 0, 0, 0);
        add_row(639, cls_ok, 0, 1, cst(16'h0300), 0, 0, 0, 0);
        add_row(100, cls_ok, 0, 3, cst(16'h0180), t_var, t_add, 0, 0);
        add_row(500, cls_ok, 0, 3, cst(16'hFDC0), t_var, t_sub, 0, 0);
        add_row(47, cls_ok, 0, 3, cst(16'hFE40), t_var, t_mul, 0, 0);
        add_row(611, cls_ok, 0, 3, cst(16'h0300), t_var, t_div, 0, 0);
        add_row(5, cls_ok, 0, 3, t_var, cst(16'hFF80), t_div, 0, 0);
        // products and sums that wrap
        add_row(320, cls_ok, 0, 3, cst(16'h0400), cst(16'h7F00), t_mul, 0, 0);
        add_row(320, cls_ok, 0, 3, cst(16'h7F00), cst(16'h7F00), t_add, 0, 0);
        add_row(200, cls_dz, 0, 3, cst(16'h0000), t_var, t_div, 0, 0);
        add_row(320, cls_ok, 0, 1, cst(16'h0100), 0, 0, 0, 0);
        add_row(10, cls_se, 0, 2, t_var, t_add, 0, 0, 0);
        open_row(320, cls_se, 0);
        for (j = 0; j < 17; j++) begin
            tab_tok.push_back(cst(16'h0100 + 16'(j)));
        end
        close_row();
        add_row(320, cls_se, 0, 2, cst(16'h0100), cst(16'h0200), 0, 0, 0);
        // two divides keep the machine busy for the lock checks
        add_row(600, cls_ok, 1, 5, cst(16'h0300), cst(16'h0180), t_var, t_div, t_div);
        for (n = 0; n < 50; n++) begin
            open_row({$random(seed)} % 640, cls_any, 0);
            push_operand();
            k = 1 + {$random(seed)} % 4;
            for (j = 0; j < k; j++) begin
                push_operand();
                tab_tok.push_back(t_add | 17'({$random(seed)} % 4));
            end
            close_row();
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] rd;
        int          i;
        for (i = 0; i < tab_len[r]; i++) begin
            apb_write(reg_tok_base + 12'(4 * i), 32'(tab_tok[tab_first[r] + i]));
        end
        apb_write(reg_len, tab_len[r]);
        apb_write(reg_x_in, tab_x[r]);
        row_class <= tab_cls[r];
        apb_write(reg_ctrl, 32'd1);
        if (tab_probe[r]) begin
            apb_write(reg_len, 32'h3F);
            apb_write(reg_tok_base, 32'h1_FFFF);
            apb_write(reg_ctrl, 32'd1);
            apb_read(reg_status, rd);
        end
        rd = '0;
        while (!rd[1]) begin
            apb_read(reg_status, rd);
        end
        apb_read(reg_y_out, rd);
        if (tab_probe[r]) begin
            apb_read(reg_len, rd);
            apb_read(reg_tok_base, rd);
            apb_read(reg_x_in, rd);
            apb_read(reg_ctrl, rd);
        end
    endtask

    initial begin
        logic [31:0] rd;
        int          r;
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        row_class = cls_any;
        cycles    = 0;
        limit     = 0;
        seed      = 32'h2d33_eca9;
        build_table();
        limit = tab_first.size() * (64 * 24 + 200);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        apb_read(reg_status, rd);
        // unmapped and misaligned accesses
        apb_write(12'h014, 32'd5);
        apb_read(12'h200, rd);
        apb_read(12'h102, rd);
        for (r = 0; r < tab_first.size(); r++) begin
            run_row(r);
        end
        repeat (4) @(posedge clk);
        $display("tests run %0d of %0d, errors %0d", tests, tab_first.size(), errors);
        if (errors == 0 && tests == tab_first.size()) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/plot_pkg.sv
rtl/plot_ifs.sv
rtl/plot_regs.sv
rtl/fixed_point_alu.sv
rtl/stack_machine.sv
rtl/plot_eval_top.sv
sim/plot_checker.sv
sim/tb_plot_eval.sv
